/* hdl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // --------------------
    // Address and block geometry
    // --------------------
    localparam int ADDR_W         = 32;
    localparam int BLOCK_W        = 128;
    localparam int BYTE_ADDR_BITS = 4;             // 16 bytes per block.

    // --------------------
    // Set and way organization
    // --------------------
    localparam int SETNUM  = 8;
    localparam int SET_W   = $clog2(SETNUM);
    localparam int DEGREES = 4;                    // Ways per set.
    localparam int WAY_W   = $clog2(DEGREES);

    // Address layout is tag, then set, then byte offset.
    localparam int TAGSIZE = ADDR_W - SET_W - BYTE_ADDR_BITS;

    localparam int SRC_W = 4;                      // L1 source/destination tag.

    // Controller states.
    typedef enum logic [1:0] {
        COMP_TAG,
        WRITE_BACK,
        ALLOCATE
    } cache_state_e;

endpackage

`default_nettype wire

/* hdl/l2_tag_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_tag_lookup (
    input  wire logic [mem_pkg::ADDR_W-1:0]                        addr_i,
    input  wire logic [mem_pkg::DEGREES-1:0][mem_pkg::TAGSIZE-1:0] way_tags_i,
    input  wire logic [mem_pkg::DEGREES-1:0]                       way_valid_i,
    output logic                                                   hit_o,
    output logic [mem_pkg::WAY_W-1:0]                              hit_way_o,
    output logic [mem_pkg::SET_W-1:0]                              set_o,
    output logic [mem_pkg::TAGSIZE-1:0]                            tag_o
);

    import mem_pkg::*;

    logic [DEGREES-1:0] match;

    // --------------------
    // Address split
    // --------------------
    assign tag_o = addr_i[ADDR_W-1 -: TAGSIZE];
    assign set_o = addr_i[BYTE_ADDR_BITS +: SET_W];

    // --------------------
    // Parallel compare
    // --------------------
    always_comb begin
        for (int w = 0; w < DEGREES; w++) begin
            match[w] = way_valid_i[w] && (way_tags_i[w] == tag_o);
        end
    end

    assign hit_o = |match;

    // Lowest matching way wins.
    always_comb begin
        hit_way_o = '0;
        for (int w = DEGREES - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way_o = WAY_W'(w);
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/l2_lru.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_lru (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    input  wire logic [mem_pkg::SET_W-1:0] set_i,
    input  wire logic                      touch_i,
    input  wire logic [mem_pkg::WAY_W-1:0] touch_way_i,
    output logic [mem_pkg::WAY_W-1:0]      victim_way_o
);

    import mem_pkg::*;

    // Entry 0 is most recent, entry DEGREES-1 least recent.
    logic [WAY_W-1:0] order_q   [SETNUM][DEGREES];
    logic [WAY_W-1:0] order_nxt [DEGREES];
    logic [WAY_W-1:0] pos;

    // --------------------
    // Move-to-front
    // --------------------
    always_comb begin
        pos = '0;
        for (int i = 0; i < DEGREES; i++) begin
            if (order_q[set_i][i] == touch_way_i) begin
                pos = WAY_W'(i);
            end
        end
        order_nxt[0] = touch_way_i;
        for (int i = 1; i < DEGREES; i++) begin
            if (i <= int'(pos)) begin
                order_nxt[i] = order_q[set_i][i-1];  // Shift back by one.
            end else begin
                order_nxt[i] = order_q[set_i][i];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < SETNUM; s++) begin
                for (int i = 0; i < DEGREES; i++) begin
                    order_q[s][i] <= WAY_W'(i);
                end
            end
        end else if (touch_i) begin
            for (int i = 0; i < DEGREES; i++) begin
                order_q[set_i][i] <= order_nxt[i];
            end
        end
    end

    assign victim_way_o = order_q[set_i][DEGREES-1];

endmodule

`default_nettype wire

/* hdl/l2_cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_ctrl (
    input  wire logic                                              clk_i,
    input  wire logic                                              rst_i,
    // L1 side.
    input  wire logic                                              l1_valid_i,
    input  wire logic                                              l1_wen_i,
    input  wire logic [mem_pkg::ADDR_W-1:0]                        l1_addr_i,
    input  wire logic [mem_pkg::BLOCK_W-1:0]                       l1_wdata_i,
    input  wire logic [mem_pkg::SRC_W-1:0]                         l1_src_i,
    output logic                                                   l1_ready_o,
    output logic [mem_pkg::BLOCK_W-1:0]                            l1_rdata_o,
    output logic [mem_pkg::SRC_W-1:0]                              l1_dst_o,
    // Memory side.
    output logic                                                   mem_valid_o,
    output logic                                                   mem_wen_o,
    output logic [mem_pkg::ADDR_W-1:0]                             mem_addr_o,
    output logic [mem_pkg::BLOCK_W-1:0]                            mem_wdata_o,
    input  wire logic                                              mem_ready_i,
    input  wire logic [mem_pkg::BLOCK_W-1:0]                       mem_rdata_i,
    // Lookup.
    input  wire logic                                              hit_i,
    input  wire logic [mem_pkg::WAY_W-1:0]                         hit_way_i,
    input  wire logic [mem_pkg::SET_W-1:0]                         set_i,
    input  wire logic [mem_pkg::TAGSIZE-1:0]                       tag_i,
    output logic [mem_pkg::DEGREES-1:0][mem_pkg::TAGSIZE-1:0]      way_tags_o,
    output logic [mem_pkg::DEGREES-1:0]                            way_valid_o,
    // Replacement.
    input  wire logic [mem_pkg::WAY_W-1:0]                         victim_way_i,
    output logic                                                   touch_o,
    output logic [mem_pkg::WAY_W-1:0]                              touch_way_o
);

    import mem_pkg::*;

    cache_state_e state_q;
    cache_state_e state_d;

    logic [DEGREES-1:0][TAGSIZE-1:0] tag_q   [SETNUM];
    logic [BLOCK_W-1:0]              data_q  [SETNUM][DEGREES];
    logic [DEGREES-1:0]              valid_q [SETNUM];
    logic [DEGREES-1:0]              dirty_q [SETNUM];

    logic hit_ack;
    logic victim_dirty;
    logic fill_done;

    // --------------------
    // Lookup and L1 response
    // --------------------
    assign way_tags_o  = tag_q[set_i];
    assign way_valid_o = valid_q[set_i];

    assign hit_ack      = (state_q == COMP_TAG) && l1_valid_i && hit_i;
    assign victim_dirty = valid_q[set_i][victim_way_i] && dirty_q[set_i][victim_way_i];
    assign fill_done    = (state_q == ALLOCATE) && mem_ready_i;

    assign l1_ready_o = hit_ack;
    assign l1_rdata_o = data_q[set_i][hit_way_i];
    assign l1_dst_o   = l1_src_i;                  // Echo the source tag.

    assign touch_o     = hit_ack;
    assign touch_way_o = hit_way_i;

    // --------------------
    // Memory request
    // --------------------
    always_comb begin
        mem_valid_o = 1'b0;
        mem_wen_o   = 1'b0;
        mem_addr_o  = {l1_addr_i[ADDR_W-1:BYTE_ADDR_BITS], {BYTE_ADDR_BITS{1'b0}}};
        mem_wdata_o = '0;
        case (state_q)
            WRITE_BACK: begin
                mem_valid_o = 1'b1;
                mem_wen_o   = 1'b1;
                // Victim address rebuilt from its stored tag.
                mem_addr_o  = {tag_q[set_i][victim_way_i], set_i, {BYTE_ADDR_BITS{1'b0}}};
                mem_wdata_o = data_q[set_i][victim_way_i];
            end
            ALLOCATE: begin
                mem_valid_o = 1'b1;
            end
            default: begin
                mem_valid_o = 1'b0;
            end
        endcase
    end

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            COMP_TAG: begin
                if (l1_valid_i && !hit_i) begin
                    state_d = victim_dirty ? WRITE_BACK : ALLOCATE;
                end
            end
            WRITE_BACK: begin
                if (mem_ready_i) begin
                    state_d = ALLOCATE;
                end
            end
            ALLOCATE: begin
                if (mem_ready_i) begin
                    state_d = COMP_TAG;        // Retry hits next cycle.
                end
            end
            default: begin
                state_d = COMP_TAG;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= COMP_TAG;
            for (int s = 0; s < SETNUM; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            state_q <= state_d;
            if (hit_ack && l1_wen_i) begin
                dirty_q[set_i][hit_way_i] <= 1'b1;
            end
            if (fill_done) begin
                valid_q[set_i][victim_way_i] <= 1'b1;
                dirty_q[set_i][victim_way_i] <= 1'b0;
            end
        end
    end

    // Line payload.
    always_ff @(posedge clk_i) begin
        if (hit_ack && l1_wen_i) begin
            data_q[set_i][hit_way_i] <= l1_wdata_i;
        end
        if (fill_done) begin
            data_q[set_i][victim_way_i] <= mem_rdata_i;
            tag_q[set_i][victim_way_i]  <= tag_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/l2_cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_top (
    input  wire logic                        clk_i,
    input  wire logic                        rst_i,
    // L1 side.
    input  wire logic                        l1_valid_i,
    input  wire logic                        l1_wen_i,
    input  wire logic [mem_pkg::ADDR_W-1:0]  l1_addr_i,
    input  wire logic [mem_pkg::BLOCK_W-1:0] l1_wdata_i,
    input  wire logic [mem_pkg::SRC_W-1:0]   l1_src_i,
    output logic                             l1_ready_o,
    output logic [mem_pkg::BLOCK_W-1:0]      l1_rdata_o,
    output logic [mem_pkg::SRC_W-1:0]        l1_dst_o,
    // Memory side.
    output logic                             mem_valid_o,
    output logic                             mem_wen_o,
    output logic [mem_pkg::ADDR_W-1:0]       mem_addr_o,
    output logic [mem_pkg::BLOCK_W-1:0]      mem_wdata_o,
    input  wire logic                        mem_ready_i,
    input  wire logic [mem_pkg::BLOCK_W-1:0] mem_rdata_i
);

    import mem_pkg::*;

    logic                            hit;
    logic [WAY_W-1:0]                hit_way;
    logic [SET_W-1:0]                set_idx;
    logic [TAGSIZE-1:0]              tag;
    logic [DEGREES-1:0][TAGSIZE-1:0] way_tags;
    logic [DEGREES-1:0]              way_valid;
    logic [WAY_W-1:0]                victim_way;
    logic                            touch;
    logic [WAY_W-1:0]                touch_way;

    // --------------------
    // Tag lookup
    // --------------------
    l2_tag_lookup u_lookup (
        .addr_i      (l1_addr_i),
        .way_tags_i  (way_tags),
        .way_valid_i (way_valid),
        .hit_o       (hit),
        .hit_way_o   (hit_way),
        .set_o       (set_idx),
        .tag_o       (tag)
    );

    // --------------------
    // Replacement
    // --------------------
    l2_lru u_lru (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .set_i        (set_idx),
        .touch_i      (touch),
        .touch_way_i  (touch_way),
        .victim_way_o (victim_way)
    );

    // --------------------
    // Controller
    // --------------------
    l2_cache_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .l1_valid_i   (l1_valid_i),
        .l1_wen_i     (l1_wen_i),
        .l1_addr_i    (l1_addr_i),
        .l1_wdata_i   (l1_wdata_i),
        .l1_src_i     (l1_src_i),
        .l1_ready_o   (l1_ready_o),
        .l1_rdata_o   (l1_rdata_o),
        .l1_dst_o     (l1_dst_o),
        .mem_valid_o  (mem_valid_o),
        .mem_wen_o    (mem_wen_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ready_i  (mem_ready_i),
        .mem_rdata_i  (mem_rdata_i),
        .hit_i        (hit),
        .hit_way_i    (hit_way),
        .set_i        (set_idx),
        .tag_i        (tag),
        .way_tags_o   (way_tags),
        .way_valid_o  (way_valid),
        .victim_way_i (victim_way),
        .touch_o      (touch),
        .touch_way_o  (touch_way)
    );

endmodule

`default_nettype wire

/* test/l2_cache_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_asserts (
    input wire logic                         clk_i,
    input wire logic                         rst_i,
    input wire logic [1:0]                   state_i,
    input wire logic                         l1_ready_i,
    input wire logic                         mem_valid_i,
    input wire logic                         mem_wen_i,
    input wire logic [mem_pkg::ADDR_W-1:0]   mem_addr_i,
    input wire logic [mem_pkg::BLOCK_W-1:0]  mem_wdata_i,
    input wire logic                         mem_ready_i
);

    import mem_pkg::*;

    // --------------------
    // Memory handshake
    // --------------------
    assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_valid_i && !mem_ready_i) |=>
            (mem_valid_i && $stable(mem_wen_i) && $stable(mem_addr_i) && $stable(mem_wdata_i)))
    else $error("Memory request changed before mem_ready_i");

    // Victim block and requested block never share an address.
    assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_valid_i && mem_wen_i && mem_ready_i) |=>
            (mem_valid_i && !mem_wen_i && (mem_addr_i != $past(mem_addr_i))))
    else $error("Write-back not followed by a fetch of another block");

    // --------------------
    // State checks
    // --------------------
    assert property (@(posedge clk_i) disable iff (rst_i)
        ((state_i == ALLOCATE) && mem_ready_i) |=> l1_ready_i)
    else $error("Request did not hit in the cycle after its line was filled");

endmodule

bind l2_cache_ctrl l2_cache_asserts u_asserts (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .state_i     (state_q),
    .l1_ready_i  (l1_ready_o),
    .mem_valid_i (mem_valid_o),
    .mem_wen_i   (mem_wen_o),
    .mem_addr_i  (mem_addr_o),
    .mem_wdata_i (mem_wdata_o),
    .mem_ready_i (mem_ready_i)
);

`default_nettype wire

/* test/l2_cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb;

    import mem_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 16;
    localparam int N_RANDOM   = 300;
    localparam int N_DIRECTED = 20;
    localparam int N_REQUESTS = N_RANDOM + N_DIRECTED;

    logic               clk_i;
    logic               rst_i;
    logic               l1_valid_i;
    logic               l1_wen_i;
    logic [ADDR_W-1:0]  l1_addr_i;
    logic [BLOCK_W-1:0] l1_wdata_i;
    logic [SRC_W-1:0]   l1_src_i;
    logic               l1_ready_o;
    logic [BLOCK_W-1:0] l1_rdata_o;
    logic [SRC_W-1:0]   l1_dst_o;
    logic               mem_valid_o;
    logic               mem_wen_o;
    logic [ADDR_W-1:0]  mem_addr_o;
    logic [BLOCK_W-1:0] mem_wdata_o;
    logic               mem_ready_i;
    logic [BLOCK_W-1:0] mem_rdata_i;

    // Cache mirror and memory contents.
    logic [TAGSIZE-1:0] ref_tag   [SETNUM][DEGREES];
    logic               ref_valid [SETNUM][DEGREES];
    logic               ref_dirty [SETNUM][DEGREES];
    logic [BLOCK_W-1:0] ref_data  [SETNUM][DEGREES];
    logic [WAY_W-1:0]   ref_order [SETNUM][DEGREES];
    logic [BLOCK_W-1:0] ref_mem   [logic [ADDR_W-1:0]];
    logic [BLOCK_W-1:0] mem_model [logic [ADDR_W-1:0]];

    logic [ADDR_W-1:0]  exp_rd_q[$];
    logic [ADDR_W-1:0]  exp_wb_addr_q[$];
    logic [BLOCK_W-1:0] exp_wb_data_q[$];
    logic               exp_wen_q[$];
    logic [BLOCK_W-1:0] exp_data_q[$];
    logic [SRC_W-1:0]   exp_dst_q[$];

    logic [31:0] stim_seed = 32'd77068;
    logic [31:0] mem_seed  = 32'd77068;
    logic        mem_busy  = 1'b0;
    int          mem_delay = 0;
    int          err_count = 0;
    int          check_count = 0;
    int          rd_count = 0;
    int          wb_count = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          test_err_base = 0;

    l2_cache_top uut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .l1_valid_i  (l1_valid_i),
        .l1_wen_i    (l1_wen_i),
        .l1_addr_i   (l1_addr_i),
        .l1_wdata_i  (l1_wdata_i),
        .l1_src_i    (l1_src_i),
        .l1_ready_o  (l1_ready_o),
        .l1_rdata_o  (l1_rdata_o),
        .l1_dst_o    (l1_dst_o),
        .mem_valid_o (mem_valid_o),
        .mem_wen_o   (mem_wen_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ready_i (mem_ready_i),
        .mem_rdata_i (mem_rdata_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Untouched memory reads back a pattern built from its address.
    function automatic logic [BLOCK_W-1:0] fill_pattern(input logic [ADDR_W-1:0] a);
        return {a, ~a, a ^ 32'hc3a5_5a3c, {a[15:0], a[31:16]}};
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int set, input int off);
        return {TAGSIZE'(tag), SET_W'(set), BYTE_ADDR_BITS'(off)};
    endfunction

    function automatic logic [BLOCK_W-1:0] rand_block();
        logic [BLOCK_W-1:0] b;
        for (int k = 0; k < BLOCK_W / 32; k++) begin
            stim_seed = lcg_next(stim_seed);
            b[k*32 +: 32] = stim_seed;
        end
        return b;
    endfunction

    task automatic init_mirror();
        for (int s = 0; s < SETNUM; s++) begin
            for (int w = 0; w < DEGREES; w++) begin
                ref_tag[s][w]   = '0;
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_data[s][w]  = '0;
                ref_order[s][w] = WAY_W'(w);     // Way 0 most recent.
            end
        end
    endtask

    // Expected read data; queues the memory traffic the access must cause.
    function automatic logic [BLOCK_W-1:0] ref_access(input logic wen,
                                                      input logic [ADDR_W-1:0] addr,
                                                      input logic [BLOCK_W-1:0] wdata);
        logic [TAGSIZE-1:0] tag;
        logic [SET_W-1:0]   set;
        logic [ADDR_W-1:0]  line;
        logic [ADDR_W-1:0]  victim;
        int                 way;
        int                 pos;
        tag  = addr[ADDR_W-1 -: TAGSIZE];
        set  = addr[BYTE_ADDR_BITS +: SET_W];
        line = {addr[ADDR_W-1:BYTE_ADDR_BITS], {BYTE_ADDR_BITS{1'b0}}};
        way  = -1;
        for (int w = DEGREES - 1; w >= 0; w--) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
                way = w;
            end
        end
        if (way < 0) begin
            way = int'(ref_order[set][DEGREES-1]);   // LRU way.
            if (ref_valid[set][way] && ref_dirty[set][way]) begin
                victim = {ref_tag[set][way], set, {BYTE_ADDR_BITS{1'b0}}};
                exp_wb_addr_q.push_back(victim);
                exp_wb_data_q.push_back(ref_data[set][way]);
                ref_mem[victim] = ref_data[set][way];
            end
            exp_rd_q.push_back(line);
            ref_data[set][way]  = ref_mem.exists(line) ? ref_mem[line] : fill_pattern(line);
            ref_tag[set][way]   = tag;
            ref_valid[set][way] = 1'b1;
            ref_dirty[set][way] = 1'b0;
        end
        if (wen) begin
            ref_data[set][way]  = wdata;
            ref_dirty[set][way] = 1'b1;
        end
        pos = 0;
        for (int i = 0; i < DEGREES; i++) begin
            if (int'(ref_order[set][i]) == way) begin
                pos = i;
            end
        end
        for (int i = pos; i > 0; i--) begin
            ref_order[set][i] = ref_order[set][i-1];
        end
        ref_order[set][0] = WAY_W'(way);
        return ref_data[set][way];
    endfunction

    task automatic check(input string name, input logic [BLOCK_W-1:0] got,
                         input logic [BLOCK_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic l1_request(input logic wen, input logic [ADDR_W-1:0] addr,
                              input logic [BLOCK_W-1:0] wdata, input int src,
                              output logic [BLOCK_W-1:0] rdata);
        logic [BLOCK_W-1:0] exp;
        exp = ref_access(wen, addr, wdata);
        exp_wen_q.push_back(wen);
        exp_data_q.push_back(exp);
        exp_dst_q.push_back(SRC_W'(src));
        l1_valid_i = 1'b1;
        l1_wen_i   = wen;
        l1_addr_i  = addr;
        l1_wdata_i = wdata;
        l1_src_i   = SRC_W'(src);
        do begin
            @(posedge clk_i);
        end while (!l1_ready_o);
        rdata = l1_rdata_o;
        @(negedge clk_i);
        l1_valid_i = 1'b0;
    endtask

    task automatic serve_memory();
        logic [ADDR_W-1:0] a;
        a = mem_addr_o;
        check("mem_addr_o offset", BLOCK_W'(a[BYTE_ADDR_BITS-1:0]), '0);
        if (mem_wen_o) begin
            wb_count++;
            if (exp_wb_addr_q.size() == 0) begin
                err_count++;
                $display("Unexpected write-back to address %h at %0t ns", a, $time);
            end else begin
                check("mem_addr_o", BLOCK_W'(a), BLOCK_W'(exp_wb_addr_q.pop_front()));
                check("mem_wdata_o", mem_wdata_o, exp_wb_data_q.pop_front());
            end
            mem_model[a] = mem_wdata_o;
        end else begin
            rd_count++;
            if (exp_rd_q.size() == 0) begin
                err_count++;
                $display("Unexpected memory read of address %h at %0t ns", a, $time);
            end else begin
                check("mem_addr_o", BLOCK_W'(a), BLOCK_W'(exp_rd_q.pop_front()));
            end
            mem_rdata_i = mem_model.exists(a) ? mem_model[a] : fill_pattern(a);
        end
    endtask

    task automatic finish_test(input string name);
        if (exp_rd_q.size() != 0 || exp_wb_addr_q.size() != 0) begin
            err_count++;
            $display("Expected memory transfers did not take place in test %s", name);
        end
        tests_run++;
        if (err_count == test_err_base) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("Test %0d %s: %0d errors", tests_run, name, err_count - test_err_base);
        end
        test_err_base = err_count;
    endtask

    // --------------------
    // Memory model
    // --------------------
    initial begin
        mem_ready_i = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(negedge clk_i);
            if (mem_ready_i) begin
                mem_ready_i = 1'b0;                  // One-cycle ready.
                mem_busy    = 1'b0;
            end else if (mem_valid_o && !rst_i) begin
                if (!mem_busy) begin
                    mem_busy  = 1'b1;
                    mem_seed  = lcg_next(mem_seed);
                    mem_delay = int'(mem_seed[17:16]) + 1;
                end
                mem_delay--;
                if (mem_delay == 0) begin
                    serve_memory();
                    mem_ready_i = 1'b1;
                end
            end
        end
    end

    // L1 response compare.
    initial begin
        logic               wen_e;
        logic [BLOCK_W-1:0] data_e;
        logic [SRC_W-1:0]   dst_e;
        forever begin
            @(posedge clk_i);
            if (!rst_i && l1_ready_o) begin
                if (exp_wen_q.size() == 0) begin
                    err_count++;
                    $display("L1 response at %0t ns with no request outstanding", $time);
                end else begin
                    wen_e  = exp_wen_q.pop_front();
                    data_e = exp_data_q.pop_front();
                    dst_e  = exp_dst_q.pop_front();
                    if (!wen_e) begin
                        check("l1_rdata_o", l1_rdata_o, data_e);
                    end
                    check("l1_dst_o", BLOCK_W'(l1_dst_o), BLOCK_W'(dst_e));
                end
            end
        end
    end

    initial begin
        repeat (N_REQUESTS * 20 + RST_CYCLES) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d cycles",
                 N_REQUESTS * 20 + RST_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        logic [BLOCK_W-1:0] blk;
        logic [BLOCK_W-1:0] first_blk;
        logic [BLOCK_W-1:0] w_blk;
        logic [31:0]        r;
        int                 rd_before;
        int                 wb_before;
        rst_i      = 1'b1;
        l1_valid_i = 1'b0;
        l1_wen_i   = 1'b0;
        l1_addr_i  = '0;
        l1_wdata_i = '0;
        l1_src_i   = '0;
        init_mirror();
        repeat (RST_CYCLES) @(negedge clk_i);
        rst_i = 1'b0;

        rd_before = rd_count;
        l1_request(1'b0, make_addr(32'h1a2b, 1, 4), '0, 3, first_blk);
        check("l1_rdata_o", first_blk, fill_pattern(make_addr(32'h1a2b, 1, 0)));
        check("memory reads", BLOCK_W'(rd_count), BLOCK_W'(rd_before + 1));
        finish_test("cold read");

        rd_before = rd_count;
        l1_request(1'b0, make_addr(32'h1a2b, 1, 8), '0, 5, blk);
        check("l1_rdata_o", blk, fill_pattern(make_addr(32'h1a2b, 1, 0)));
        check("memory reads", BLOCK_W'(rd_count), BLOCK_W'(rd_before));
        finish_test("read hit");

        rd_before = rd_count;
        wb_before = wb_count;
        w_blk = rand_block();
        l1_request(1'b1, make_addr(32'h1a2b, 1, 0), w_blk, 6, blk);
        l1_request(1'b0, make_addr(32'h1a2b, 1, 12), '0, 7, blk);
        check("l1_rdata_o", blk, w_blk);
        check("memory reads", BLOCK_W'(rd_count), BLOCK_W'(rd_before));
        check("write-backs", BLOCK_W'(wb_count), BLOCK_W'(wb_before));
        finish_test("write hit then read");

        l1_request(1'b0, make_addr(32'h100, 2, 0), '0, 1, blk);
        l1_request(1'b1, make_addr(32'h100, 2, 0), rand_block(), 2, blk);
        for (int t = 1; t < 4; t++) begin
            l1_request(1'b0, make_addr(32'h100 + t, 2, 0), '0, t, blk);
        end
        wb_before = wb_count;
        l1_request(1'b0, make_addr(32'h104, 2, 0), '0, 9, blk);
        check("write-backs", BLOCK_W'(wb_count), BLOCK_W'(wb_before + 1));
        finish_test("LRU eviction");

        for (int t = 0; t < 4; t++) begin
            l1_request(1'b0, make_addr(32'h200 + t, 5, 0), '0, t, blk);
        end
        // Oldest fill is 0x200, but the touches leave the dirty 0x201 least recent.
        w_blk = rand_block();
        l1_request(1'b1, make_addr(32'h201, 5, 0), w_blk, 4, blk);
        for (int t = 0; t < 4; t++) begin
            if (t != 1) begin
                l1_request(1'b0, make_addr(32'h200 + t, 5, 0), '0, t, blk);   // Touch order.
            end
        end
        wb_before = wb_count;
        l1_request(1'b0, make_addr(32'h204, 5, 0), '0, 10, blk);
        check("write-backs", BLOCK_W'(wb_count), BLOCK_W'(wb_before + 1));
        rd_before = rd_count;
        l1_request(1'b0, make_addr(32'h201, 5, 4), '0, 11, blk);
        check("l1_rdata_o", blk, w_blk);
        check("memory reads", BLOCK_W'(rd_count), BLOCK_W'(rd_before + 1));
        finish_test("touch order and refetch");

        for (int i = 0; i < N_RANDOM; i++) begin
            stim_seed = lcg_next(stim_seed);
            r = stim_seed;
            w_blk = rand_block();
            l1_request(r[31], make_addr(32'h40 + int'(r[24:22]), int'(r[20:19]),
                       int'(r[28:25])), w_blk, i, blk);
        end
        finish_test("random traffic");

        $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, check_count, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* l2_cache_top.f */
hdl/mem_pkg.sv
hdl/l2_tag_lookup.sv
hdl/l2_lru.sv
hdl/l2_cache_ctrl.sv
hdl/l2_cache_top.sv
test/l2_cache_asserts.sv
test/l2_cache_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the L2 cache testbench; the log decides the result.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
    --top-module l2_cache_tb -f l2_cache_top.f -o l2_cache_sim \
    && ./obj_dir/l2_cache_sim > sim.log 2>&1
[ -f sim.log ] && cat sim.log

grep -q "^PASS: all tests$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
